// ==== Bender.yml ====
package:
  name: c2s_chan

sources:
  - logic/c2s_pkg.sv
  - logic/c2s_fifo.sv
  - logic/axil_reg_port.sv
  - logic/c2s_ctrl_regs.sv
  - logic/c2s_burst_ctrl.sv
  - logic/c2s_front_buff.sv
  - logic/c2s_chan.sv
  - target: test
    files:
      - verification/c2s_chan_properties.sv
      - verification/c2s_chan_tb.sv

// ==== c2s_chan.f ====
logic/c2s_pkg.sv
logic/c2s_fifo.sv
logic/axil_reg_port.sv
logic/c2s_ctrl_regs.sv
logic/c2s_burst_ctrl.sv
logic/c2s_front_buff.sv
logic/c2s_chan.sv
verification/c2s_chan_properties.sv
verification/c2s_chan_tb.sv

// ==== logic/axil_reg_port.sv ====
module axil_reg_port
(
	input  logic s_axi_clk,
	input  logic s_axi_rstn,
	input  logic [c2s_pkg::AXIL_ADDR_W-1:0] s_axil_awaddr_i,
	input  logic s_axil_awvalid_i,
	output logic s_axil_awready_o,
	input  logic [c2s_pkg::AXIL_DATA_W-1:0] s_axil_wdata_i,
	input  logic s_axil_wvalid_i,
	output logic s_axil_wready_o,
	output logic [1:0] s_axil_bresp_o,
	output logic s_axil_bvalid_o,
	input  logic s_axil_bready_i,
	input  logic [c2s_pkg::AXIL_ADDR_W-1:0] s_axil_araddr_i,
	input  logic s_axil_arvalid_i,
	output logic s_axil_arready_o,
	output logic [c2s_pkg::AXIL_DATA_W-1:0] s_axil_rdata_o,
	output logic [1:0] s_axil_rresp_o,
	output logic s_axil_rvalid_o,
	input  logic s_axil_rready_i,
	output c2s_pkg::reg_wr_t reg_wr_o,
	output logic [c2s_pkg::REG_IDX_W-1:0] rd_index_o,
	input  logic [c2s_pkg::AXIL_DATA_W-1:0] rd_word_i
);
	import c2s_pkg::*;

	localparam logic [1:0] RESP_OKAY = 2'b00;

	logic wr_hs;
	logic rd_hs;

	// address and data taken together with one write in flight
	assign wr_hs = s_axil_awvalid_i && s_axil_wvalid_i && !s_axil_bvalid_o;
	assign s_axil_awready_o = wr_hs;
	assign s_axil_wready_o = wr_hs;
	assign s_axil_bresp_o = RESP_OKAY;

	// byte address to word index
	assign reg_wr_o.valid = wr_hs;
	assign reg_wr_o.index = REG_IDX_W'(s_axil_awaddr_i[AXIL_ADDR_W-1:2]);
	assign reg_wr_o.value = s_axil_wdata_i;

	assign rd_hs = s_axil_arvalid_i && !s_axil_rvalid_o;
	assign s_axil_arready_o = rd_hs;
	assign s_axil_rresp_o = RESP_OKAY;
	assign rd_index_o = REG_IDX_W'(s_axil_araddr_i[AXIL_ADDR_W-1:2]);

	always_ff @(posedge s_axi_clk)
	begin
		if (!s_axi_rstn)
		begin
			s_axil_bvalid_o <= 1'b0;
			s_axil_rvalid_o <= 1'b0;
		end
		else
		begin
			if (wr_hs)
				s_axil_bvalid_o <= 1'b1;
			else if (s_axil_bready_i)
				s_axil_bvalid_o <= 1'b0;
			if (rd_hs)
				s_axil_rvalid_o <= 1'b1;
			else if (s_axil_rready_i)
				s_axil_rvalid_o <= 1'b0;
		end
	end

	// word selected in the accept cycle
	always_ff @(posedge s_axi_clk)
	begin
		if (rd_hs)
			s_axil_rdata_o <= rd_word_i;
	end

endmodule

// ==== logic/c2s_burst_ctrl.sv ====
module c2s_burst_ctrl
(
	input  logic s_axi_clk,
	input  logic s_axi_rstn,
	input  logic sys_ena_i,
	input  c2s_pkg::chan_cmd_t cmd_i,
	input  logic [c2s_pkg::LEN_W-1:0] max_payload_size_i,
	input  logic [c2s_pkg::DATA_W-1:0] s_axis_tdata_i,
	input  logic [c2s_pkg::KEEP_W-1:0] s_axis_tkeep_i,
	input  logic s_axis_tlast_i,
	input  logic s_axis_tvalid_i,
	output logic s_axis_tready_o,
	input  logic data_full_i,
	input  logic burst_full_i,
	output logic data_push_o,
	output c2s_pkg::stream_beat_t data_o,
	output logic burst_push_o,
	output c2s_pkg::burst_req_t burst_o,
	output logic running_o,
	output logic burst_closed_o
);
	import c2s_pkg::*;

	logic running_q;
	logic beat_hs;
	logic run_end;
	logic close;
	logic [LEN_W-1:0] beat_bytes;
	logic [LEN_W-1:0] byte_sum;
	logic [LEN_W-1:0] byte_cnt_q;
	logic [ADDR_W-1:0] addr_q;
	logic [TAG_W-3:0] tag_cnt_q;

	// hold off one cycle after a close so the burst queue flags catch up
	assign s_axis_tready_o = running_q && !data_full_i && !burst_full_i && !burst_push_o;
	assign beat_hs = s_axis_tvalid_i && s_axis_tready_o;

	assign data_push_o = beat_hs;
	assign data_o.data = s_axis_tdata_i;
	assign data_o.keep = s_axis_tkeep_i;
	assign data_o.last = s_axis_tlast_i;

	// only the last beat may be partial and it counts whole dwords
	assign beat_bytes = s_axis_tlast_i ? LEN_W'(4 * $countones(s_axis_tkeep_i))
		: LEN_W'(BEAT_BYTES);
	assign byte_sum = beat_hs ? byte_cnt_q + beat_bytes : byte_cnt_q;

	assign run_end = running_q && (cmd_i.stop || !cmd_i.ena || !sys_ena_i);

	// payload limit, tlast, or the channel going down with bytes pending
	assign close = (beat_hs && (s_axis_tlast_i || (byte_sum >= max_payload_size_i)))
		|| (run_end && (byte_sum != '0));

	always_ff @(posedge s_axi_clk)
	begin
		if (!s_axi_rstn)
		begin
			running_q <= 1'b0;
			byte_cnt_q <= '0;
			tag_cnt_q <= '0;
			burst_push_o <= 1'b0;
		end
		else
		begin
			burst_push_o <= close;
			if (run_end)
				running_q <= 1'b0;
			else if (cmd_i.start && cmd_i.ena && sys_ena_i)
				running_q <= 1'b1;
			if (close)
				byte_cnt_q <= '0;
			else
				byte_cnt_q <= byte_sum;
			if (close)
				tag_cnt_q <= tag_cnt_q + 1'b1;
		end
	end

	// next burst starts where the last one ended
	always_ff @(posedge s_axi_clk)
	begin
		if (cmd_i.start && !running_q)
			addr_q <= cmd_i.addr;
		else if (close)
			addr_q <= addr_q + ADDR_W'(byte_sum);
		if (close)
		begin
			burst_o.addr <= addr_q;
			burst_o.len <= byte_sum;
			burst_o.tag <= {CHAN_ID, tag_cnt_q};
		end
	end

	assign running_o = running_q;
	assign burst_closed_o = burst_push_o;

endmodule

// ==== logic/c2s_chan.sv ====
module c2s_chan
(
	input  logic s_axi_clk,
	input  logic s_axi_rstn,
	input  logic sys_ena_i,
	input  logic [c2s_pkg::AXIL_ADDR_W-1:0] s_axil_awaddr_i,
	input  logic s_axil_awvalid_i,
	output logic s_axil_awready_o,
	input  logic [c2s_pkg::AXIL_DATA_W-1:0] s_axil_wdata_i,
	input  logic s_axil_wvalid_i,
	output logic s_axil_wready_o,
	output logic [1:0] s_axil_bresp_o,
	output logic s_axil_bvalid_o,
	input  logic s_axil_bready_i,
	input  logic [c2s_pkg::AXIL_ADDR_W-1:0] s_axil_araddr_i,
	input  logic s_axil_arvalid_i,
	output logic s_axil_arready_o,
	output logic [c2s_pkg::AXIL_DATA_W-1:0] s_axil_rdata_o,
	output logic [1:0] s_axil_rresp_o,
	output logic s_axil_rvalid_o,
	input  logic s_axil_rready_i,
	input  logic [c2s_pkg::DATA_W-1:0] s_axis_tdata_i,
	input  logic [c2s_pkg::KEEP_W-1:0] s_axis_tkeep_i,
	input  logic s_axis_tlast_i,
	input  logic s_axis_tvalid_i,
	output logic s_axis_tready_o,
	input  logic [c2s_pkg::LEN_W-1:0] max_payload_size_i,
	output logic tx_arbit_req_o,
	input  logic tx_arbit_grnt_i,
	output logic [c2s_pkg::LEN_W-1:0] tx_burst_len_o,
	output logic [c2s_pkg::ADDR_W-1:0] tx_burst_sys_addr_o,
	output logic [c2s_pkg::TAG_W-1:0] tx_burst_tag_o,
	input  logic read_req_i,
	output logic [c2s_pkg::DATA_W-1:0] read_data_o
);
	import c2s_pkg::*;

	reg_wr_t reg_wr;
	logic [REG_IDX_W-1:0] rd_index;
	logic [AXIL_DATA_W-1:0] rd_word;
	chan_cmd_t cmd;
	logic running;
	logic burst_closed;
	logic data_push;
	stream_beat_t data_beat;
	logic burst_push;
	burst_req_t burst;
	logic data_full;
	logic burst_full;

	axil_reg_port axil_reg_port_inst (
		.s_axi_clk        (s_axi_clk),
		.s_axi_rstn       (s_axi_rstn),
		.s_axil_awaddr_i  (s_axil_awaddr_i),
		.s_axil_awvalid_i (s_axil_awvalid_i),
		.s_axil_awready_o (s_axil_awready_o),
		.s_axil_wdata_i   (s_axil_wdata_i),
		.s_axil_wvalid_i  (s_axil_wvalid_i),
		.s_axil_wready_o  (s_axil_wready_o),
		.s_axil_bresp_o   (s_axil_bresp_o),
		.s_axil_bvalid_o  (s_axil_bvalid_o),
		.s_axil_bready_i  (s_axil_bready_i),
		.s_axil_araddr_i  (s_axil_araddr_i),
		.s_axil_arvalid_i (s_axil_arvalid_i),
		.s_axil_arready_o (s_axil_arready_o),
		.s_axil_rdata_o   (s_axil_rdata_o),
		.s_axil_rresp_o   (s_axil_rresp_o),
		.s_axil_rvalid_o  (s_axil_rvalid_o),
		.s_axil_rready_i  (s_axil_rready_i),
		.reg_wr_o         (reg_wr),
		.rd_index_o       (rd_index),
		.rd_word_i        (rd_word)
	);

	c2s_ctrl_regs c2s_ctrl_regs_inst (
		.s_axi_clk      (s_axi_clk),
		.s_axi_rstn     (s_axi_rstn),
		.reg_wr_i       (reg_wr),
		.rd_index_i     (rd_index),
		.rd_word_o      (rd_word),
		.running_i      (running),
		.burst_closed_i (burst_closed),
		.cmd_o          (cmd)
	);

	c2s_burst_ctrl c2s_burst_ctrl_inst (
		.s_axi_clk          (s_axi_clk),
		.s_axi_rstn         (s_axi_rstn),
		.sys_ena_i          (sys_ena_i),
		.cmd_i              (cmd),
		.max_payload_size_i (max_payload_size_i),
		.s_axis_tdata_i     (s_axis_tdata_i),
		.s_axis_tkeep_i     (s_axis_tkeep_i),
		.s_axis_tlast_i     (s_axis_tlast_i),
		.s_axis_tvalid_i    (s_axis_tvalid_i),
		.s_axis_tready_o    (s_axis_tready_o),
		.data_full_i        (data_full),
		.burst_full_i       (burst_full),
		.data_push_o        (data_push),
		.data_o             (data_beat),
		.burst_push_o       (burst_push),
		.burst_o            (burst),
		.running_o          (running),
		.burst_closed_o     (burst_closed)
	);

	c2s_front_buff c2s_front_buff_inst (
		.s_axi_clk           (s_axi_clk),
		.s_axi_rstn          (s_axi_rstn),
		.data_push_i         (data_push),
		.data_i              (data_beat),
		.burst_push_i        (burst_push),
		.burst_i             (burst),
		.data_full_o         (data_full),
		.burst_full_o        (burst_full),
		.tx_arbit_req_o      (tx_arbit_req_o),
		.tx_arbit_grnt_i     (tx_arbit_grnt_i),
		.tx_burst_len_o      (tx_burst_len_o),
		.tx_burst_sys_addr_o (tx_burst_sys_addr_o),
		.tx_burst_tag_o      (tx_burst_tag_o),
		.read_req_i          (read_req_i),
		.read_data_o         (read_data_o)
	);

endmodule

// ==== logic/c2s_ctrl_regs.sv ====
module c2s_ctrl_regs
(
	input  logic s_axi_clk,
	input  logic s_axi_rstn,
	input  c2s_pkg::reg_wr_t reg_wr_i,
	input  logic [c2s_pkg::REG_IDX_W-1:0] rd_index_i,
	output logic [c2s_pkg::AXIL_DATA_W-1:0] rd_word_o,
	input  logic running_i,
	input  logic burst_closed_i,
	output c2s_pkg::chan_cmd_t cmd_o
);
	import c2s_pkg::*;

	logic ctrl_wr;
	logic ena_q;
	logic start_q;
	logic stop_q;
	logic [ADDR_W-1:0] start_addr_q;
	logic [AXIL_DATA_W-1:0] burst_cnt_q;

	assign ctrl_wr = reg_wr_i.valid && (reg_wr_i.index == REG_CTRL);

	always_ff @(posedge s_axi_clk)
	begin
		if (!s_axi_rstn)
		begin
			ena_q <= 1'b0;
			start_q <= 1'b0;
			stop_q <= 1'b0;
			burst_cnt_q <= '0;
		end
		else
		begin
			// start and stop are write-only pulses
			start_q <= ctrl_wr && reg_wr_i.value[CTRL_START_BIT];
			stop_q <= ctrl_wr && reg_wr_i.value[CTRL_STOP_BIT];
			if (ctrl_wr)
				ena_q <= reg_wr_i.value[CTRL_ENA_BIT];
			if (start_q)
				burst_cnt_q <= '0;
			else if (burst_closed_i)
				burst_cnt_q <= burst_cnt_q + 1'b1;
		end
	end

	always_ff @(posedge s_axi_clk)
	begin
		if (reg_wr_i.valid && (reg_wr_i.index == REG_ADDR_LO))
			start_addr_q[AXIL_DATA_W-1:0] <= reg_wr_i.value;
		if (reg_wr_i.valid && (reg_wr_i.index == REG_ADDR_HI))
			start_addr_q[ADDR_W-1:AXIL_DATA_W] <= reg_wr_i.value;
	end

	assign cmd_o.start = start_q;
	assign cmd_o.stop = stop_q;
	assign cmd_o.ena = ena_q;
	assign cmd_o.addr = start_addr_q;

	always_comb
	begin
		rd_word_o = '0;
		case (rd_index_i)
			REG_CTRL:
			begin
				rd_word_o[CTRL_ENA_BIT] = ena_q;
				rd_word_o[CTRL_RUN_BIT] = running_i;
			end
			REG_ADDR_LO: rd_word_o = start_addr_q[AXIL_DATA_W-1:0];
			REG_ADDR_HI: rd_word_o = start_addr_q[ADDR_W-1:AXIL_DATA_W];
			REG_BURST_CNT: rd_word_o = burst_cnt_q;
			default: rd_word_o = '0;
		endcase
	end

endmodule

// ==== logic/c2s_fifo.sv ====
module c2s_fifo
#(
	parameter type payload_t = logic,
	parameter int DEPTH_LOG2 = 2
)
(
	input  logic s_axi_clk,
	input  logic s_axi_rstn,
	input  logic push_i,
	input  payload_t push_data_i,
	input  logic pop_i,
	output payload_t pop_data_o,
	output logic empty_o,
	output logic full_o
);

	// extra pointer bit tells full from empty
	logic [DEPTH_LOG2:0] wr_ptr_q;
	logic [DEPTH_LOG2:0] rd_ptr_q;
	logic do_push;
	logic do_pop;
	payload_t mem [2**DEPTH_LOG2];

	assign do_push = push_i && !full_o;
	assign do_pop = pop_i && !empty_o;

	assign empty_o = (wr_ptr_q == rd_ptr_q);
	assign full_o = (wr_ptr_q[DEPTH_LOG2] != rd_ptr_q[DEPTH_LOG2])
		&& (wr_ptr_q[DEPTH_LOG2-1:0] == rd_ptr_q[DEPTH_LOG2-1:0]);

	// head entry is always on the output
	assign pop_data_o = mem[rd_ptr_q[DEPTH_LOG2-1:0]];

	always_ff @(posedge s_axi_clk)
	begin
		if (!s_axi_rstn)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (do_pop)
				rd_ptr_q <= rd_ptr_q + 1'b1;
		end
	end

	always_ff @(posedge s_axi_clk)
	begin
		if (do_push)
			mem[wr_ptr_q[DEPTH_LOG2-1:0]] <= push_data_i;
	end

endmodule

// ==== logic/c2s_front_buff.sv ====
module c2s_front_buff
(
	input  logic s_axi_clk,
	input  logic s_axi_rstn,
	input  logic data_push_i,
	input  c2s_pkg::stream_beat_t data_i,
	input  logic burst_push_i,
	input  c2s_pkg::burst_req_t burst_i,
	output logic data_full_o,
	output logic burst_full_o,
	output logic tx_arbit_req_o,
	input  logic tx_arbit_grnt_i,
	output logic [c2s_pkg::LEN_W-1:0] tx_burst_len_o,
	output logic [c2s_pkg::ADDR_W-1:0] tx_burst_sys_addr_o,
	output logic [c2s_pkg::TAG_W-1:0] tx_burst_tag_o,
	input  logic read_req_i,
	output logic [c2s_pkg::DATA_W-1:0] read_data_o
);
	import c2s_pkg::*;

	logic data_empty;
	logic burst_empty;
	stream_beat_t data_head;
	burst_req_t burst_head;

	c2s_fifo #(
		.payload_t  (stream_beat_t),
		.DEPTH_LOG2 (BUFF_DEPTH_LOG2)
	) data_fifo_inst (
		.s_axi_clk   (s_axi_clk),
		.s_axi_rstn  (s_axi_rstn),
		.push_i      (data_push_i),
		.push_data_i (data_i),
		.pop_i       (read_req_i),
		.pop_data_o  (data_head),
		.empty_o     (data_empty),
		.full_o      (data_full_o)
	);

	c2s_fifo #(
		.payload_t  (burst_req_t),
		.DEPTH_LOG2 (BURST_DEPTH_LOG2)
	) burst_fifo_inst (
		.s_axi_clk   (s_axi_clk),
		.s_axi_rstn  (s_axi_rstn),
		.push_i      (burst_push_i),
		.push_data_i (burst_i),
		.pop_i       (tx_arbit_grnt_i),
		.pop_data_o  (burst_head),
		.empty_o     (burst_empty),
		.full_o      (burst_full_o)
	);

	// head burst is offered until granted
	assign tx_arbit_req_o = !burst_empty;
	assign tx_burst_len_o = burst_head.len;
	assign tx_burst_sys_addr_o = burst_head.addr;
	assign tx_burst_tag_o = burst_head.tag;

	// beat data follows read_req by one cycle and holds when empty
	always_ff @(posedge s_axi_clk)
	begin
		if (read_req_i && !data_empty)
			read_data_o <= data_head.data;
	end

endmodule

// ==== logic/c2s_pkg.sv ====
package c2s_pkg;

	// stream and buffer geometry
	localparam int DATA_W = 128;
	localparam int KEEP_W = DATA_W / 32;
	localparam int BEAT_BYTES = DATA_W / 8;
	localparam int ADDR_W = 64;
	localparam int LEN_W = 13;
	localparam int TAG_W = 8;
	// upper two bits of every tag
	localparam logic [1:0] CHAN_ID = 2'd0;
	localparam int BUFF_DEPTH_LOG2 = 6;
	localparam int BURST_DEPTH_LOG2 = 2;

	// host register port
	localparam int AXIL_ADDR_W = 4;
	localparam int AXIL_DATA_W = 32;
	localparam int REG_IDX_W = 4;
	localparam logic [REG_IDX_W-1:0] REG_CTRL = 4'd0;
	localparam logic [REG_IDX_W-1:0] REG_ADDR_LO = 4'd1;
	localparam logic [REG_IDX_W-1:0] REG_ADDR_HI = 4'd2;
	localparam logic [REG_IDX_W-1:0] REG_BURST_CNT = 4'd3;

	// control register bits
	localparam int CTRL_ENA_BIT = 0;
	localparam int CTRL_RUN_BIT = 1;
	localparam int CTRL_START_BIT = 2;
	localparam int CTRL_STOP_BIT = 7;

	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [KEEP_W-1:0] keep;
		logic last;
	} stream_beat_t;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [LEN_W-1:0] len;
		logic [TAG_W-1:0] tag;
	} burst_req_t;

	typedef struct packed {
		logic valid;
		logic [REG_IDX_W-1:0] index;
		logic [AXIL_DATA_W-1:0] value;
	} reg_wr_t;

	typedef struct packed {
		logic start;
		logic stop;
		logic ena;
		logic [ADDR_W-1:0] addr;
	} chan_cmd_t;

endpackage

// ==== verification/c2s_chan_properties.sv ====
module c2s_chan_properties
(
	input  logic s_axi_clk,
	input  logic s_axi_rstn,
	input  logic sys_ena_i,
	input  logic [c2s_pkg::AXIL_ADDR_W-1:0] s_axil_awaddr_i,
	input  logic s_axil_awvalid_i,
	input  logic s_axil_awready_o,
	input  logic [c2s_pkg::AXIL_DATA_W-1:0] s_axil_wdata_i,
	input  logic s_axil_wready_o,
	input  logic [1:0] s_axil_bresp_o,
	input  logic s_axil_bvalid_o,
	input  logic [c2s_pkg::AXIL_ADDR_W-1:0] s_axil_araddr_i,
	input  logic s_axil_arvalid_i,
	input  logic s_axil_arready_o,
	input  logic [c2s_pkg::AXIL_DATA_W-1:0] s_axil_rdata_o,
	input  logic [1:0] s_axil_rresp_o,
	input  logic s_axil_rvalid_o,
	input  logic [c2s_pkg::DATA_W-1:0] s_axis_tdata_i,
	input  logic [c2s_pkg::KEEP_W-1:0] s_axis_tkeep_i,
	input  logic s_axis_tlast_i,
	input  logic s_axis_tvalid_i,
	input  logic s_axis_tready_o,
	input  logic [c2s_pkg::LEN_W-1:0] max_payload_size_i,
	input  logic tx_arbit_req_o,
	input  logic tx_arbit_grnt_i,
	input  logic [c2s_pkg::LEN_W-1:0] tx_burst_len_o,
	input  logic [c2s_pkg::ADDR_W-1:0] tx_burst_sys_addr_o,
	input  logic [c2s_pkg::TAG_W-1:0] tx_burst_tag_o,
	input  logic read_req_i,
	input  logic [c2s_pkg::DATA_W-1:0] read_data_o
);
	timeunit 1ns;
	timeprecision 1ps;
	import c2s_pkg::*;

	int unsigned fail_cnt = 0;
	logic wr_hs;
	logic [REG_IDX_W-1:0] wr_idx;
	logic [AXIL_DATA_W-1:0] addr_lo_q;
	logic [AXIL_DATA_W-1:0] addr_hi_q;
	logic ena_q;
	logic run_q;
	logic stop_d1_q;
	logic stopped_q;
	logic [AXIL_DATA_W-1:0] grant_cnt_q;
	logic [TAG_W-3:0] tag_cnt_q;
	logic [ADDR_W-1:0] next_addr_q;
	logic [AXIL_DATA_W-1:0] exp_rdata_q;
	logic [DATA_W-1:0] exp_data_q;
	logic [LEN_W-1:0] pend_q;
	logic [LEN_W-1:0] exp_len_head;
	logic [DATA_W-1:0] beat_q[$];
	logic [LEN_W-1:0] len_q[$];

	assign wr_hs = s_axil_awvalid_i && s_axil_awready_o;
	assign wr_idx = REG_IDX_W'(s_axil_awaddr_i[AXIL_ADDR_W-1:2]);
	assign exp_len_head = (len_q.size() > 0) ? len_q[0] : '0;

	// shadow of the register file and the channel state
	always @(posedge s_axi_clk)
	begin
		logic [LEN_W-1:0] sum;
		logic [AXIL_DATA_W-1:0] word;
		if (!s_axi_rstn)
		begin
			ena_q <= 1'b0;
			run_q <= 1'b0;
			stop_d1_q <= 1'b0;
			stopped_q <= 1'b0;
			grant_cnt_q <= '0;
			tag_cnt_q <= '0;
			pend_q <= '0;
			beat_q.delete();
			len_q.delete();
		end
		else
		begin
			stop_d1_q <= wr_hs && (wr_idx == REG_CTRL) && s_axil_wdata_i[CTRL_STOP_BIT];
			if (stop_d1_q)
				stopped_q <= 1'b1;
			if (wr_hs && wr_idx == REG_ADDR_LO)
				addr_lo_q <= s_axil_wdata_i;
			if (wr_hs && wr_idx == REG_ADDR_HI)
				addr_hi_q <= s_axil_wdata_i;
			if (wr_hs && wr_idx == REG_CTRL)
			begin
				ena_q <= s_axil_wdata_i[CTRL_ENA_BIT];
				if (s_axil_wdata_i[CTRL_STOP_BIT] || !s_axil_wdata_i[CTRL_ENA_BIT])
					run_q <= 1'b0;
				else if (s_axil_wdata_i[CTRL_START_BIT] && sys_ena_i)
					run_q <= 1'b1;
				if (s_axil_wdata_i[CTRL_START_BIT])
				begin
					stopped_q <= 1'b0;
					grant_cnt_q <= '0;
					next_addr_q <= {addr_hi_q, addr_lo_q};
				end
			end
			// bursts close on payload limit, tlast or stop with bytes pending
			sum = pend_q;
			if (s_axis_tvalid_i && s_axis_tready_o)
			begin
				beat_q.push_back(s_axis_tdata_i);
				sum = sum + (s_axis_tlast_i ? LEN_W'(4 * $countones(s_axis_tkeep_i))
					: LEN_W'(BEAT_BYTES));
				if (s_axis_tlast_i || sum >= max_payload_size_i)
				begin
					len_q.push_back(sum);
					sum = '0;
				end
			end
			if (stop_d1_q && sum != '0)
			begin
				len_q.push_back(sum);
				sum = '0;
			end
			pend_q <= sum;
			if (tx_arbit_grnt_i)
			begin
				grant_cnt_q <= grant_cnt_q + 1'b1;
				tag_cnt_q <= tag_cnt_q + 1'b1;
				next_addr_q <= next_addr_q + ADDR_W'(exp_len_head);
				if (len_q.size() > 0)
					void'(len_q.pop_front());
			end
			if (read_req_i && beat_q.size() > 0)
				exp_data_q <= beat_q.pop_front();
			if (s_axil_arvalid_i && s_axil_arready_o)
			begin
				case (REG_IDX_W'(s_axil_araddr_i[AXIL_ADDR_W-1:2]))
					REG_CTRL: word = {30'b0, run_q, ena_q};
					REG_ADDR_LO: word = addr_lo_q;
					REG_ADDR_HI: word = addr_hi_q;
					REG_BURST_CNT: word = grant_cnt_q;
					default: word = '0;
				endcase
				exp_rdata_q <= word;
			end
		end
	end

	reset_outputs_low: assert property (@(posedge s_axi_clk)
		!s_axi_rstn |=> (!tx_arbit_req_o && !s_axis_tready_o
		&& !s_axil_bvalid_o && !s_axil_rvalid_o))
	else
	begin
		$error("control outputs not low after reset");
		fail_cnt++;
	end

	write_resp_okay: assert property (@(posedge s_axi_clk) disable iff (!s_axi_rstn)
		(s_axil_awvalid_i && s_axil_awready_o) |=> ($past(s_axil_wready_o)
		&& s_axil_bvalid_o && s_axil_bresp_o == 2'b00))
	else
	begin
		$error("[ERROR] s_axil_bresp_o 0x%h bvalid 0x%h expected 0x0 bvalid 0x1",
			s_axil_bresp_o, s_axil_bvalid_o);
		fail_cnt++;
	end

	read_word_match: assert property (@(posedge s_axi_clk) disable iff (!s_axi_rstn)
		(s_axil_arvalid_i && s_axil_arready_o) |=> (s_axil_rvalid_o
		&& s_axil_rresp_o == 2'b00 && s_axil_rdata_o == exp_rdata_q))
	else
	begin
		$error("[ERROR] s_axil_rdata_o 0x%h expected 0x%h rresp 0x%h rvalid 0x%h",
			s_axil_rdata_o, exp_rdata_q, s_axil_rresp_o, s_axil_rvalid_o);
		fail_cnt++;
	end

	burst_len_limit: assert property (@(posedge s_axi_clk) disable iff (!s_axi_rstn)
		tx_arbit_grnt_i |-> (tx_burst_len_o <= max_payload_size_i && tx_burst_len_o != 0))
	else
	begin
		$error("[ERROR] tx_burst_len_o 0x%h outside 0x1 to max 0x%h", tx_burst_len_o,
			max_payload_size_i);
		fail_cnt++;
	end

	burst_len_match: assert property (@(posedge s_axi_clk) disable iff (!s_axi_rstn)
		tx_arbit_grnt_i |-> (tx_burst_len_o == exp_len_head))
	else
	begin
		$error("[ERROR] tx_burst_len_o 0x%h expected 0x%h", tx_burst_len_o, exp_len_head);
		fail_cnt++;
	end

	burst_addr_chain: assert property (@(posedge s_axi_clk) disable iff (!s_axi_rstn)
		tx_arbit_grnt_i |-> (tx_burst_sys_addr_o == next_addr_q))
	else
	begin
		$error("[ERROR] tx_burst_sys_addr_o 0x%h expected 0x%h", tx_burst_sys_addr_o,
			next_addr_q);
		fail_cnt++;
	end

	burst_tag_match: assert property (@(posedge s_axi_clk) disable iff (!s_axi_rstn)
		tx_arbit_grnt_i |-> (tx_burst_tag_o == {CHAN_ID, tag_cnt_q}))
	else
	begin
		$error("[ERROR] tx_burst_tag_o 0x%h expected 0x%h", tx_burst_tag_o,
			{CHAN_ID, tag_cnt_q});
		fail_cnt++;
	end

	read_data_order: assert property (@(posedge s_axi_clk) disable iff (!s_axi_rstn)
		read_req_i |=> (read_data_o == exp_data_q))
	else
	begin
		$error("[ERROR] read_data_o 0x%h expected 0x%h", read_data_o, exp_data_q);
		fail_cnt++;
	end

	ready_low_after_stop: assert property (@(posedge s_axi_clk) disable iff (!s_axi_rstn)
		stopped_q |-> !s_axis_tready_o)
	else
	begin
		$error("s_axis_tready_o high after the channel was stopped");
		fail_cnt++;
	end

endmodule

bind c2s_chan c2s_chan_properties props_inst (.*);

// ==== verification/c2s_chan_tb.sv ====
module c2s_chan_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import c2s_pkg::*;

	localparam time CLK_PERIOD = 100ns;
	// beats sent over all tests and a bound of cycles per beat
	localparam int TOTAL_BEATS = 10 + 3 + 20 + 40 + 2;
	localparam int CYCLES_PER_BEAT = 40;
	localparam int REG_CYCLES = 2000;
	// long enough for the burst queue to fill
	localparam int HOLD_CYCLES = 60;

	logic s_axi_clk;
	logic s_axi_rstn;
	logic sys_ena_i;
	logic [AXIL_ADDR_W-1:0] s_axil_awaddr_i;
	logic s_axil_awvalid_i;
	logic s_axil_awready_o;
	logic [AXIL_DATA_W-1:0] s_axil_wdata_i;
	logic s_axil_wvalid_i;
	logic s_axil_wready_o;
	logic [1:0] s_axil_bresp_o;
	logic s_axil_bvalid_o;
	logic s_axil_bready_i;
	logic [AXIL_ADDR_W-1:0] s_axil_araddr_i;
	logic s_axil_arvalid_i;
	logic s_axil_arready_o;
	logic [AXIL_DATA_W-1:0] s_axil_rdata_o;
	logic [1:0] s_axil_rresp_o;
	logic s_axil_rvalid_o;
	logic s_axil_rready_i;
	logic [DATA_W-1:0] s_axis_tdata_i;
	logic [KEEP_W-1:0] s_axis_tkeep_i;
	logic s_axis_tlast_i;
	logic s_axis_tvalid_i;
	logic s_axis_tready_o;
	logic [LEN_W-1:0] max_payload_size_i;
	logic tx_arbit_req_o;
	logic tx_arbit_grnt_i;
	logic [LEN_W-1:0] tx_burst_len_o;
	logic [ADDR_W-1:0] tx_burst_sys_addr_o;
	logic [TAG_W-1:0] tx_burst_tag_o;
	logic read_req_i;
	logic [DATA_W-1:0] read_data_o;

	int seed = 32'h9f4e0331;
	int tests_run = 0;
	logic hold_grants = 1'b0;
	logic disp_busy = 1'b0;

	c2s_chan c2s_chan_inst (.*);

	initial
	begin
		s_axi_clk = 1'b0;
		forever
			#(CLK_PERIOD / 2) s_axi_clk = ~s_axi_clk;
	end

	initial
	begin
		#(CLK_PERIOD * (REG_CYCLES + TOTAL_BEATS * CYCLES_PER_BEAT));
		$display("watchdog expired before the tests completed");
		$display("Testbench failed");
		$finish;
	end

	// dispatcher model with a random grant delay and then one read per beat
	always
	begin
		int beats;
		@(posedge s_axi_clk);
		if (tx_arbit_req_o && !hold_grants && s_axi_rstn)
		begin
			disp_busy <= 1'b1;
			repeat ($unsigned($random(seed)) % 4)
				@(posedge s_axi_clk);
			beats = (tx_burst_len_o + BEAT_BYTES - 1) / BEAT_BYTES;
			tx_arbit_grnt_i <= 1'b1;
			@(posedge s_axi_clk);
			tx_arbit_grnt_i <= 1'b0;
			for (int i = 0; i < beats; i++)
			begin
				read_req_i <= 1'b1;
				@(posedge s_axi_clk);
				read_req_i <= 1'b0;
				if ($random(seed) & 1)
					@(posedge s_axi_clk);
			end
			disp_busy <= 1'b0;
		end
	end

	task automatic reg_write(input logic [REG_IDX_W-1:0] idx, input logic [31:0] value);
		s_axil_awaddr_i <= {idx[1:0], 2'b00};
		s_axil_wdata_i <= value;
		s_axil_awvalid_i <= 1'b1;
		s_axil_wvalid_i <= 1'b1;
		do
			@(posedge s_axi_clk);
		while (!s_axil_awready_o);
		s_axil_awvalid_i <= 1'b0;
		s_axil_wvalid_i <= 1'b0;
		repeat (3)
			@(posedge s_axi_clk);
	endtask

	task automatic reg_read(input logic [REG_IDX_W-1:0] idx);
		s_axil_araddr_i <= {idx[1:0], 2'b00};
		s_axil_arvalid_i <= 1'b1;
		do
			@(posedge s_axi_clk);
		while (!s_axil_arready_o);
		s_axil_arvalid_i <= 1'b0;
		repeat (3)
			@(posedge s_axi_clk);
	endtask

	// one packet of random beats with tlast on the final one if asked
	task automatic send_packet(input int beats, input logic with_last,
		input logic [KEEP_W-1:0] last_keep);
		for (int i = 0; i < beats; i++)
		begin
			s_axis_tdata_i <= {$random(seed), $random(seed), $random(seed), $random(seed)};
			s_axis_tlast_i <= with_last && (i == beats - 1);
			s_axis_tkeep_i <= (with_last && i == beats - 1) ? last_keep : '1;
			s_axis_tvalid_i <= 1'b1;
			do
				@(posedge s_axi_clk);
			while (!s_axis_tready_o);
			s_axis_tvalid_i <= 1'b0;
			if (($random(seed) & 3) == 0)
				@(posedge s_axi_clk);
		end
	endtask

	task automatic drain_bursts();
		repeat (4)
			@(posedge s_axi_clk);
		while (tx_arbit_req_o || disp_busy)
			@(posedge s_axi_clk);
		repeat (2)
			@(posedge s_axi_clk);
	endtask

	task automatic end_test(input string name);
		tests_run++;
		$display("test %0d %s finished, assertion failures so far %0d", tests_run, name,
			c2s_chan_inst.props_inst.fail_cnt);
	endtask

	initial
	begin
		s_axi_rstn = 1'b0;
		sys_ena_i = 1'b1;
		s_axil_awaddr_i = '0;
		s_axil_awvalid_i = 1'b0;
		s_axil_wdata_i = '0;
		s_axil_wvalid_i = 1'b0;
		s_axil_bready_i = 1'b1;
		s_axil_araddr_i = '0;
		s_axil_arvalid_i = 1'b0;
		s_axil_rready_i = 1'b1;
		s_axis_tdata_i = '0;
		s_axis_tkeep_i = '0;
		s_axis_tlast_i = 1'b0;
		s_axis_tvalid_i = 1'b0;
		max_payload_size_i = 13'd64;
		tx_arbit_grnt_i = 1'b0;
		read_req_i = 1'b0;
		repeat (10)
			@(posedge s_axi_clk);
		s_axi_rstn <= 1'b1;
		repeat (2)
			@(posedge s_axi_clk);
		end_test("reset state");

		reg_write(REG_ADDR_LO, 32'h1000_0f00);
		reg_write(REG_ADDR_HI, 32'h0000_00a5);
		reg_read(REG_ADDR_LO);
		reg_read(REG_ADDR_HI);
		reg_write(REG_CTRL, 32'h0000_0005);
		reg_read(REG_CTRL);
		end_test("register access and start");

		send_packet(10, 1'b1, 4'b0011);
		send_packet(3, 1'b1, 4'b0001);
		send_packet(20, 1'b1, 4'b1111);
		drain_bursts();
		reg_read(REG_BURST_CNT);
		end_test("burst split and data order");

		hold_grants <= 1'b1;
		fork
			send_packet(40, 1'b1, 4'b0111);
			begin
				repeat (HOLD_CYCLES)
					@(posedge s_axi_clk);
				hold_grants <= 1'b0;
			end
		join
		drain_bursts();
		end_test("dispatcher back-pressure");

		send_packet(2, 1'b0, 4'b1111);
		reg_write(REG_CTRL, 32'h0000_0081);
		s_axis_tvalid_i <= 1'b1;
		repeat (5)
			@(posedge s_axi_clk);
		s_axis_tvalid_i <= 1'b0;
		drain_bursts();
		reg_read(REG_CTRL);
		end_test("stop with partial burst");

		reg_read(REG_BURST_CNT);
		end_test("burst count");

		$display("tests run %0d, assertion failures %0d", tests_run,
			c2s_chan_inst.props_inst.fail_cnt);
		if (c2s_chan_inst.props_inst.fail_cnt == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule
